//--- sim.f
rtl/MipsPkg.sv
rtl/InstrStreamIf.sv
rtl/Fetch.sv
rtl/FetchQueue.sv
rtl/RegFile.sv
rtl/Execute.sv
rtl/Datapath.sv
verification/DatapathAsserts.sv
verification/DatapathTb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module DatapathTb -f sim.f -o simv
	./obj_dir/simv +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/DatapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module DatapathTb;
    import MipsPkg::*;

    localparam int NumInstr    = 256;
    localparam int ClkPeriod   = 10;
    localparam int ResetCycles = 16;
    localparam int BurstStart  = 150; // Cycle after reset where WbReady drops.
    localparam int BurstLen    = 20;

    logic        clk;
    logic        rstN;
    logic [31:0] IAddr;
    logic [31:0] IRead;
    logic        WbValid;
    logic        WbReady;
    logic [31:0] WbPc;
    logic [4:0]  WbReg;
    logic [31:0] WbData;
    logic        WbIllegal;

    logic [31:0] rom [256];
    logic [31:0] modelRegs [32];
    logic [31:0] retired;
    logic [31:0] curWord;
    logic        expLegal;
    logic        expIllegal;
    logic [4:0]  expReg;
    logic [31:0] expData;
    logic [31:0] expPc;
    int          timeouts = 0;

    Datapath u_Datapath (
        .clk       (clk),
        .rstN      (rstN),
        .IAddr     (IAddr),
        .IRead     (IRead),
        .WbValid   (WbValid),
        .WbReady   (WbReady),
        .WbPc      (WbPc),
        .WbReg     (WbReg),
        .WbData    (WbData),
        .WbIllegal (WbIllegal)
    );

    bind Datapath DatapathAsserts checks (
        .clk       (clk),
        .rstN      (rstN),
        .IAddr     (IAddr),
        .WbValid   (WbValid),
        .WbReady   (WbReady),
        .WbPc      (WbPc),
        .WbReg     (WbReg),
        .WbData    (WbData),
        .WbIllegal (WbIllegal)
    );

    assign IRead = rom[IAddr[9:2]]; // Same-cycle instruction memory.

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Sources and targets stay in r0..r7 so results feed later instructions.
    function automatic logic [31:0] randomInstr();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [31:0] word;
        rs   = 5'($urandom % 8);
        rt   = 5'($urandom % 8);
        rd   = 5'($urandom % 8);
        sh   = 5'($urandom);
        imm  = 16'($urandom);
        word = $urandom;
        if ($urandom % 10 == 0) begin
            if ($urandom % 2 == 0) begin
                return {OpSpecial, word[25:6], 6'h3f}; // Unused funct.
            end
            return {2'b10, word[29:0]}; // Opcodes 0x20..0x2f are unused.
        end
        case ($urandom % 13)
            0:       return {OpSpecial, rs, rt, rd, sh, FnSll};
            1:       return {OpSpecial, rs, rt, rd, 5'd0, FnAddu};
            2:       return {OpSpecial, rs, rt, rd, 5'd0, FnSubu};
            3:       return {OpSpecial, rs, rt, rd, 5'd0, FnAnd};
            4:       return {OpSpecial, rs, rt, rd, 5'd0, FnOr};
            5:       return {OpSpecial, rs, rt, rd, 5'd0, FnXor};
            6:       return {OpSpecial, rs, rt, rd, 5'd0, FnSlt};
            7:       return {OpAddiu, rs, rt, imm};
            8:       return {OpSlti, rs, rt, imm};
            9:       return {OpAndi, rs, rt, imm};
            10:      return {OpOri, rs, rt, imm};
            11:      return {OpXori, rs, rt, imm};
            default: return {OpLui, 5'd0, rt, imm};
        endcase
    endfunction

    // Reference decode of one word from its source register values.
    function automatic void predict(
        input  logic [31:0] word,
        input  logic [31:0] a,
        input  logic [31:0] b,
        output logic        ok,
        output logic [4:0]  dst,
        output logic [31:0] res
    );
        logic [31:0] sx;
        logic [31:0] zx;
        sx  = {{16{word[15]}}, word[15:0]};
        zx  = {16'd0, word[15:0]};
        ok  = 1'b1;
        dst = word[20:16];
        res = '0;
        if (word[31:26] == OpSpecial) begin
            dst = word[15:11];
            case (word[5:0])
                FnSll:   res = b << word[10:6];
                FnAddu:  res = a + b;
                FnSubu:  res = a - b;
                FnAnd:   res = a & b;
                FnOr:    res = a | b;
                FnXor:   res = a ^ b;
                FnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: ok = 1'b0;
            endcase
        end else begin
            case (word[31:26])
                OpAddiu: res = a + sx;
                OpSlti:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                OpAndi:  res = a & zx;
                OpOri:   res = a | zx;
                OpXori:  res = a ^ zx;
                OpLui:   res = {word[15:0], 16'd0};
                default: ok = 1'b0;
            endcase
        end
        if (!ok) begin
            dst = 5'd0;
            res = '0;
        end
    endfunction

    always_comb begin
        curWord = rom[retired[7:0]];
        predict(curWord, modelRegs[curWord[25:21]], modelRegs[curWord[20:16]],
                expLegal, expReg, expData);
        expIllegal = !expLegal;
    end

    assign expPc = {retired[29:0], 2'b00};

    // Model steps once per trace transfer.
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retired <= '0;
            for (int i = 0; i < 32; i++) begin
                modelRegs[i] <= '0;
            end
        end else if (WbValid && WbReady) begin
            if (expLegal && expReg != 5'd0) begin
                modelRegs[expReg] <= expData; // r0 keeps reading zero.
            end
            retired <= retired + 1;
        end
    end

    task automatic finishRun();
        int fails;
        fails = u_Datapath.checks.failCount;
        $display("Summary: %0d retired, %0d assertion failures, %0d timeouts",
                 retired, fails, timeouts);
        if (fails == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        int unsigned cyc;
        void'($urandom(32));
        for (int i = 0; i < 256; i++) begin
            rom[i] = randomInstr();
        end
        rstN    = 1'b0;
        WbReady = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        cyc = 0;
        while (retired < NumInstr) begin
            @(posedge clk);
            cyc++;
            if (cyc > BurstStart && cyc <= BurstStart + BurstLen) begin
                WbReady <= 1'b0; // Fills trace register, queue, then stalls fetch.
            end else begin
                WbReady <= ($urandom % 10) < 7;
            end
        end
        @(posedge clk);
        @(negedge clk); // Let the last edge's assertions settle.
        finishRun();
    end

    initial begin
        #(NumInstr * 10 * ClkPeriod);
        $display("Timeout: only %0d of %0d instructions retired", retired, NumInstr);
        timeouts++;
        finishRun();
    end

endmodule

`default_nettype wire

//--- verification/DatapathAsserts.sv
`timescale 1ns/1ps
`default_nettype none

module DatapathAsserts (
    input logic        clk,
    input logic        rstN,
    input logic [31:0] IAddr,
    input logic        WbValid,
    input logic        WbReady,
    input logic [31:0] WbPc,
    input logic [4:0]  WbReg,
    input logic [31:0] WbData,
    input logic        WbIllegal
);

    logic [31:0] expPc;
    logic [4:0]  expReg;
    logic [31:0] expData;
    logic        expIllegal;
    int          failCount = 0;

    // Next retirement predicted by the testbench model.
    assign expPc      = DatapathTb.expPc;
    assign expReg     = DatapathTb.expReg;
    assign expData    = DatapathTb.expData;
    assign expIllegal = DatapathTb.expIllegal;

    resetState: assert property (@(posedge clk) $rose(rstN) |-> !WbValid && IAddr == 32'd0)
        else begin
            failCount++;
            $error("Trace or fetch address not in reset state when reset was released");
        end

    pcMatch: assert property (@(posedge clk) disable iff (!rstN) WbValid |-> WbPc == expPc)
        else begin
            failCount++;
            $error("ERR %0t WbPc expected %h got %h", $time, $sampled(expPc), $sampled(WbPc));
        end

    regMatch: assert property (@(posedge clk) disable iff (!rstN) WbValid |-> WbReg == expReg)
        else begin
            failCount++;
            $error("ERR %0t WbReg expected %0d got %0d", $time, $sampled(expReg),
                   $sampled(WbReg));
        end

    dataMatch: assert property (@(posedge clk) disable iff (!rstN) WbValid |-> WbData == expData)
        else begin
            failCount++;
            $error("ERR %0t WbData expected %h got %h", $time, $sampled(expData),
                   $sampled(WbData));
        end

    illegalMatch: assert property (@(posedge clk) disable iff (!rstN)
                                   WbValid |-> WbIllegal == expIllegal)
        else begin
            failCount++;
            $error("ERR %0t WbIllegal expected %b got %b", $time, $sampled(expIllegal),
                   $sampled(WbIllegal));
        end

    // A stalled retirement must not move.
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        WbValid && !WbReady |=> WbValid && $stable(WbPc) && $stable(WbReg)
                                && $stable(WbData) && $stable(WbIllegal))
        else begin
            failCount++;
            $error("Trace outputs changed while the retirement was stalled");
        end

endmodule

`default_nettype wire

//--- rtl/Datapath.sv
`timescale 1ns/1ps
`default_nettype none

module Datapath (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] IAddr,
    input  logic [31:0] IRead,
    output logic        WbValid,
    input  logic        WbReady,
    output logic [31:0] WbPc,
    output logic [4:0]  WbReg,
    output logic [31:0] WbData,
    output logic        WbIllegal
);
    import MipsPkg::*;

    InstrStreamIf fetchToQueue ();
    InstrStreamIf queueToExec ();

    Fetch u_Fetch (
        .clk   (clk),
        .rstN  (rstN),
        .IAddr (IAddr),
        .IRead (IRead),
        .out   (fetchToQueue.producer)
    );

    FetchQueue #(
        .Depth (QueueDepth)
    ) u_FetchQueue (
        .clk  (clk),
        .rstN (rstN),
        .in   (fetchToQueue.consumer),
        .out  (queueToExec.producer)
    );

    Execute u_Execute (
        .clk       (clk),
        .rstN      (rstN),
        .in        (queueToExec.consumer),
        .WbValid   (WbValid),
        .WbReady   (WbReady),
        .WbPc      (WbPc),
        .WbReg     (WbReg),
        .WbData    (WbData),
        .WbIllegal (WbIllegal)
    );

endmodule

`default_nettype wire

//--- rtl/Execute.sv
`timescale 1ns/1ps
`default_nettype none

module Execute (
    input  logic              clk,
    input  logic              rstN,
    InstrStreamIf.consumer    in,
    output logic              WbValid,
    input  logic              WbReady,
    output logic [31:0]       WbPc,
    output logic [4:0]        WbReg,
    output logic [31:0]       WbData,
    output logic              WbIllegal
);
    import MipsPkg::*;

    instrFields_t instr;
    logic [31:0]  rsData;
    logic [31:0]  rtData;
    logic [31:0]  signImm;
    logic [31:0]  zeroImm;
    logic [31:0]  result;
    logic [4:0]   dest;
    logic         legal;
    logic         accept;
    logic         regWrite;

    assign instr = in.entry.instr;

    // Trace register frees up when empty or drained this cycle.
    assign in.ready = !WbValid || WbReady;
    assign accept   = in.valid && in.ready;

    assign signImm = {{16{instr.iType.imm[15]}}, instr.iType.imm};
    assign zeroImm = {16'd0, instr.iType.imm};

    RegFile u_RegFile (
        .clk    (clk),
        .rstN   (rstN),
        .rAddrA (instr.rType.rs),
        .rAddrB (instr.rType.rt),
        .rDataA (rsData),
        .rDataB (rtData),
        .wEn    (regWrite),
        .wAddr  (dest),
        .wData  (result)
    );

    always_comb begin
        legal  = 1'b1;
        dest   = instr.iType.rt; // I-type target.
        result = '0;
        case (instr.rType.opcode)
            OpSpecial: begin
                dest = instr.rType.rd;
                case (instr.rType.funct)
                    FnSll:   result = rtData << instr.rType.shamt;
                    FnAddu:  result = rsData + rtData;
                    FnSubu:  result = rsData - rtData;
                    FnAnd:   result = rsData & rtData;
                    FnOr:    result = rsData | rtData;
                    FnXor:   result = rsData ^ rtData;
                    FnSlt:   result = {31'd0, $signed(rsData) < $signed(rtData)};
                    default: legal = 1'b0;
                endcase
            end
            OpAddiu: result = rsData + signImm;
            OpSlti:  result = {31'd0, $signed(rsData) < $signed(signImm)};
            OpAndi:  result = rsData & zeroImm;
            OpOri:   result = rsData | zeroImm;
            OpXori:  result = rsData ^ zeroImm;
            OpLui:   result = {instr.iType.imm, 16'd0};
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            dest   = '0;
            result = '0;
        end
    end

    // r0 writes still retire with their data.
    assign regWrite = accept && legal && (dest != 5'd0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            WbValid <= 1'b0;
        end else if (accept) begin
            WbValid <= 1'b1;
        end else if (WbReady) begin
            WbValid <= 1'b0; // Drained, nothing new.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            WbPc      <= in.entry.pc;
            WbReg     <= dest;
            WbData    <= result;
            WbIllegal <= !legal;
        end
    end

endmodule

`default_nettype wire

//--- rtl/RegFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rAddrA,
    input  logic [4:0]  rAddrB,
    output logic [31:0] rDataA,
    output logic [31:0] rDataB,
    input  logic        wEn,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData
);

    logic [31:0] regs [1:31]; // No storage behind r0.

    assign rDataA = (rAddrA == 5'd0) ? 32'd0 : regs[rAddrA];
    assign rDataB = (rAddrB == 5'd0) ? 32'd0 : regs[rAddrB];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && (wAddr != 5'd0)) begin
            regs[wAddr] <= wData;
        end
    end

endmodule

`default_nettype wire

//--- rtl/FetchQueue.sv
`timescale 1ns/1ps
`default_nettype none

module FetchQueue #(
    parameter int Depth = MipsPkg::QueueDepth
) (
    input  logic              clk,
    input  logic              rstN,
    InstrStreamIf.consumer    in,
    InstrStreamIf.producer    out
);
    import MipsPkg::*;

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    fetchEntry_t     mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            push;
    logic            pop;

    // Ready depends on count only, never on pop.
    assign in.ready  = (count != CntW'(Depth));
    assign out.valid = (count != '0);
    assign out.entry = mem[rdPtr];

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= in.entry;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/Fetch.sv
`timescale 1ns/1ps
`default_nettype none

module Fetch (
    input  logic                  clk,
    input  logic                  rstN,
    output logic [31:0]           IAddr,
    input  logic [31:0]           IRead,
    InstrStreamIf.producer        out
);
    import MipsPkg::*;

    logic [31:0] pc;
    logic        advance;
    fetchEntry_t entry;

    assign IAddr = pc;

    // Memory answers in the same cycle, so the word is always valid.
    assign out.valid = 1'b1;

    always_comb begin
        entry.pc    = pc;
        entry.instr = IRead;
    end

    assign out.entry = entry;

    assign advance = out.valid && out.ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc + 32'd4; // Next sequential word.
        end
    end

endmodule

`default_nettype wire

//--- rtl/InstrStreamIf.sv
`timescale 1ns/1ps
`default_nettype none

interface InstrStreamIf;
    import MipsPkg::*;

    logic        valid;
    logic        ready;
    fetchEntry_t entry; // PC and instruction word.

    modport producer (
        output valid,
        output entry,
        input  ready
    );

    modport consumer (
        input  valid,
        input  entry,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/MipsPkg.sv
`default_nettype none

package MipsPkg;

    // Major opcodes.
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpSlti    = 6'h0a;
    localparam logic [5:0] OpAndi    = 6'h0c;
    localparam logic [5:0] OpOri     = 6'h0d;
    localparam logic [5:0] OpXori    = 6'h0e;
    localparam logic [5:0] OpLui     = 6'h0f;

    // SPECIAL function codes.
    localparam logic [5:0] FnSll  = 6'h00;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnXor  = 6'h26;
    localparam logic [5:0] FnSlt  = 6'h2a;

    localparam int QueueDepth = 4; // Default fetch queue depth.

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeFields_t;

    // One instruction word, two field layouts.
    typedef union packed {
        rTypeFields_t rType;
        iTypeFields_t iType;
    } instrFields_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetchEntry_t;

endpackage

`default_nettype wire
